/* hdl/alu.sv */
// operand selection, base integer ALU and the RV32M multiplier, all combinational
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  rv_pkg::ctrl_t ctrl,
    input  rv_pkg::word_t rs1_data,
    input  rv_pkg::word_t rs2_data,
    input  rv_pkg::word_t imm,
    input  rv_pkg::word_t pc,
    output rv_pkg::word_t alu_result,
    output rv_pkg::word_t mul_result
);
    import rv_pkg::*;

    word_t                    op_a;
    word_t                    op_b;
    logic [4:0]               shamt;
    logic                     a_signed;
    logic                     b_signed;
    logic signed [XLEN:0]     mul_a;
    logic signed [XLEN:0]     mul_b;
    logic signed [2*XLEN-1:0] product;

    always_comb begin
        case (ctrl.alu_a_sel)
            A_RS1:   op_a = rs1_data;
            A_IMM:   op_a = imm;
            default: op_a = '0;
        endcase
        case (ctrl.alu_b_sel)
            B_IMM:   op_b = imm;
            B_PC:    op_b = pc;
            default: op_b = rs2_data;
        endcase
    end

    assign shamt = op_b[4:0];

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:  alu_result = ctrl.sub_arith ? (op_a - op_b) : (op_a + op_b);
            ALU_SLL:  alu_result = op_a << shamt;
            ALU_SLT:  alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_result = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:  alu_result = op_a ^ op_b;
            ALU_SRL:  alu_result = ctrl.sub_arith ? word_t'($signed(op_a) >>> shamt)
                                                  : (op_a >> shamt);
            ALU_OR:   alu_result = op_a | op_b;
            default:  alu_result = op_a & op_b;
        endcase
    end

    // one extra bit per operand covers signed, unsigned and mixed
    assign a_signed = (ctrl.mul_op == MUL_MULH) || (ctrl.mul_op == MUL_MULHSU);
    assign b_signed = (ctrl.mul_op == MUL_MULH);
    assign mul_a    = {a_signed & op_a[XLEN-1], op_a};
    assign mul_b    = {b_signed & op_b[XLEN-1], op_b};

    // low 64 bits of the 66-bit product are exact
    assign product = mul_a * mul_b;

    assign mul_result = (ctrl.mul_op == MUL_MUL) ? product[XLEN-1:0]
                                                 : product[2*XLEN-1:XLEN];

endmodule

`default_nettype wire

/* hdl/branch_unit.sv */
// branch compare and next pc selection for the single-cycle core
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    input  rv_pkg::ctrl_t ctrl,
    input  rv_pkg::word_t rs1_data,
    input  rv_pkg::word_t rs2_data,
    input  rv_pkg::word_t pc,
    input  rv_pkg::word_t alu_result,
    output rv_pkg::word_t next_pc
);
    import rv_pkg::*;

    logic cond;
    logic taken;

    always_comb begin
        case (ctrl.branch_op)
            BR_BEQ:  cond = (rs1_data == rs2_data);
            BR_BNE:  cond = (rs1_data != rs2_data);
            BR_BLT:  cond = ($signed(rs1_data) < $signed(rs2_data));
            BR_BGE:  cond = ($signed(rs1_data) >= $signed(rs2_data));
            BR_BLTU: cond = (rs1_data < rs2_data);
            BR_BGEU: cond = (rs1_data >= rs2_data);
            default: cond = 1'b0;
        endcase
    end

    assign taken = ctrl.branch_always || (ctrl.branch_instr && cond);

    // jalr clears bit 0 of the target
    assign next_pc = taken ? {alu_result[XLEN-1:1], 1'b0} : (pc + word_t'(4));

    // pc is unknown until the first reset edge
    assert final ($isunknown(pc) || (next_pc[1:0] == 2'b00))
        else $error("branch_unit: misaligned next pc %h", next_pc);

endmodule

`default_nettype wire

/* hdl/decoder.sv */
// combinational RV32IM instruction decoder, turns one instruction word into immediate and controls
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  rv_pkg::word_t    instr,
    output rv_pkg::word_t    imm,
    output rv_pkg::reg_idx_t rs1,
    output rv_pkg::reg_idx_t rs2,
    output rv_pkg::reg_idx_t rd,
    output rv_pkg::ctrl_t    ctrl
);
    import rv_pkg::*;

    // base opcode map, instr[6:0]
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_ALUI   = 7'b0010011,
        OP_ALU    = 7'b0110011,
        OP_FENCE  = 7'b0001111,
        OP_SYSTEM = 7'b1110011
    } opcode_t;

    opcode_t    opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;
    word_t      imm_u;
    word_t      imm_j;
    word_t      imm_i;
    word_t      imm_b;
    word_t      imm_s;

    // R-type field split
    assign opcode = opcode_t'(instr[6:0]);
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};

    always_comb begin
        // no-op unless the opcode says otherwise
        imm                   = '0;
        ctrl.alu_a_sel        = A_ZERO;
        ctrl.alu_b_sel        = B_IMM;
        ctrl.alu_op           = ALU_ADD;
        ctrl.sub_arith        = 1'b0;
        ctrl.mul_op           = MUL_MUL;
        ctrl.branch_instr     = 1'b0;
        ctrl.branch_always    = 1'b0;
        ctrl.branch_op        = BR_BEQ;
        ctrl.dmem_we          = 1'b0;
        ctrl.dmem_re          = 1'b0;
        ctrl.dmem_sign_extend = 1'b0;
        ctrl.dmem_width       = MEM_WORD;
        ctrl.wb_sel           = WB_ALU;
        ctrl.wb_we            = 1'b0;

        case (opcode)
            OP_LUI: begin
                // 0 + imm through the adder
                imm        = imm_u;
                ctrl.wb_we = 1'b1;
            end
            OP_AUIPC: begin
                imm            = imm_u;
                ctrl.alu_a_sel = A_IMM;
                ctrl.alu_b_sel = B_PC;
                ctrl.wb_we     = 1'b1;
            end
            OP_JAL: begin
                imm                = imm_j;
                ctrl.alu_a_sel     = A_IMM;
                ctrl.alu_b_sel     = B_PC;
                ctrl.branch_always = 1'b1;
                ctrl.wb_sel        = WB_PC_PLUS_4;
                ctrl.wb_we         = 1'b1;
            end
            OP_JALR: begin
                imm                = imm_i;
                ctrl.alu_a_sel     = A_RS1;
                ctrl.branch_always = 1'b1;
                ctrl.wb_sel        = WB_PC_PLUS_4;
                ctrl.wb_we         = 1'b1;
            end
            OP_BRANCH: begin
                // adder forms the target, compare happens in the branch unit
                imm               = imm_b;
                ctrl.alu_a_sel    = A_IMM;
                ctrl.alu_b_sel    = B_PC;
                ctrl.branch_instr = 1'b1;
                ctrl.branch_op    = branch_op_t'(funct3);
            end
            OP_LOAD: begin
                imm                   = imm_i;
                ctrl.alu_a_sel        = A_RS1;
                ctrl.dmem_re          = 1'b1;
                ctrl.dmem_width       = mem_width_t'(funct3[1:0]);
                ctrl.dmem_sign_extend = !funct3[2];
                ctrl.wb_sel           = WB_MEM;
                ctrl.wb_we            = 1'b1;
            end
            OP_STORE: begin
                imm             = imm_s;
                ctrl.alu_a_sel  = A_RS1;
                ctrl.dmem_we    = 1'b1;
                ctrl.dmem_width = mem_width_t'(funct3[1:0]);
            end
            OP_ALUI: begin
                imm            = imm_i;
                ctrl.alu_a_sel = A_RS1;
                ctrl.alu_op    = alu_op_t'(funct3);
                // srai carries its flag in the immediate
                ctrl.sub_arith = (funct3 == 3'b101) ? instr[30] : 1'b0;
                ctrl.wb_we     = 1'b1;
            end
            OP_ALU: begin
                ctrl.alu_a_sel = A_RS1;
                ctrl.alu_b_sel = B_RS2;
                ctrl.wb_we     = 1'b1;
                if (funct7 == 7'b0000001) begin
                    ctrl.mul_op = mul_op_t'(funct3[1:0]);
                    ctrl.wb_sel = WB_MUL;
                end else begin
                    ctrl.alu_op    = alu_op_t'(funct3);
                    ctrl.sub_arith = instr[30];
                end
            end
            default: begin
                // fence, system and unknown opcodes retire as no-ops
            end
        endcase
    end

    // a store never writes the register file, checked once instr is known
    assert final ($isunknown(instr) || !(ctrl.wb_we && ctrl.dmem_we))
        else $error("decoder: store also writes back, instr %h", instr);

endmodule

`default_nettype wire

/* hdl/load_store_unit.sv */
// store lane placement and load lane extraction between the core and data memory
`timescale 1ns/1ps
`default_nettype none

module load_store_unit (
    input  rv_pkg::ctrl_t     ctrl,
    input  rv_pkg::word_t     addr,
    input  rv_pkg::word_t     rs2_data,
    input  rv_pkg::word_t     dmem_rdata,
    output rv_pkg::dmem_req_t dmem_req,
    output rv_pkg::word_t     load_data
);
    import rv_pkg::*;

    logic [1:0] offset;
    be_t        be;
    word_t      wdata;
    word_t      lane;
    logic       misaligned;

    assign offset = addr[1:0];

    // replicate store data so every lane sees it, byte enables pick the right one
    always_comb begin
        case (ctrl.dmem_width)
            MEM_BYTE: begin
                be    = be_t'(4'b0001 << offset);
                wdata = {4{rs2_data[7:0]}};
            end
            MEM_HALF: begin
                be    = offset[1] ? 4'b1100 : 4'b0011;
                wdata = {2{rs2_data[15:0]}};
            end
            default: begin
                be    = 4'b1111;
                wdata = rs2_data;
            end
        endcase
    end

    assign dmem_req = '{addr: addr, wdata: wdata, be: be, we: ctrl.dmem_we};

    // addressed lane moved down to bit 0
    assign lane = dmem_rdata >> {offset, 3'b000};

    always_comb begin
        case (ctrl.dmem_width)
            MEM_BYTE: load_data = {{(XLEN-8){ctrl.dmem_sign_extend & lane[7]}}, lane[7:0]};
            MEM_HALF: load_data = {{(XLEN-16){ctrl.dmem_sign_extend & lane[15]}}, lane[15:0]};
            default:  load_data = dmem_rdata;
        endcase
    end

    assign misaligned = ((ctrl.dmem_width == MEM_HALF) && offset[0]) ||
                        ((ctrl.dmem_width == MEM_WORD) && (offset != 2'b00));

    assert final ($isunknown(ctrl) || !((ctrl.dmem_re || ctrl.dmem_we) && misaligned))
        else $error("load_store_unit: misaligned access at %h", addr);

endmodule

`default_nettype wire

/* hdl/regfile.sv */
// integer register file, two combinational reads and one write at the clock edge
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic             clk,
    input  logic             reset,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    output rv_pkg::word_t    rs1_data,
    output rv_pkg::word_t    rs2_data,
    input  rv_pkg::wb_t      wb
);
    import rv_pkg::*;

    // x0 has no storage
    word_t regs [1:NREGS-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    // x0 reads zero even in the cycle after a write aimed at it
    assert property (@(posedge clk) disable iff (reset)
        (wb.we && (wb.rd == '0)) |=> ((rs1 != '0) || (rs1_data == '0)))
        else $error("regfile: x0 changed after write");

    // a written register reads back its new value on rs2
    assert property (@(posedge clk) disable iff (reset)
        (wb.we && (wb.rd != '0)) |=> ((rs2 != $past(wb.rd)) || (rs2_data == $past(wb.data))))
        else $error("regfile: rs2 does not read back the last write");

endmodule

`default_nettype wire

/* hdl/rv_core.sv */
// single-cycle RV32IM core top, pc register, write-back mux and datapath instances
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  logic              clk,
    input  logic              reset,
    output rv_pkg::word_t     imem_addr,
    input  rv_pkg::word_t     imem_data,
    output rv_pkg::dmem_req_t dmem_req,
    input  rv_pkg::word_t     dmem_rdata,
    output rv_pkg::wb_t       wb
);
    import rv_pkg::*;

    word_t     pc;
    word_t     next_pc;
    word_t     imm;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    reg_idx_t  rd;
    ctrl_t     ctrl;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     alu_result;
    word_t     mul_result;
    word_t     load_data;
    word_t     wb_data;
    dmem_req_t lsu_req;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

    assign imem_addr = pc;

    decoder i_decoder (
        .instr (imem_data),
        .imm   (imm),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd    (rd),
        .ctrl  (ctrl)
    );

    regfile i_regfile (
        .clk      (clk),
        .reset    (reset),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)
    );

    alu i_alu (
        .ctrl       (ctrl),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .imm        (imm),
        .pc         (pc),
        .alu_result (alu_result),
        .mul_result (mul_result)
    );

    branch_unit i_branch_unit (
        .ctrl       (ctrl),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .pc         (pc),
        .alu_result (alu_result),
        .next_pc    (next_pc)
    );

    load_store_unit i_load_store_unit (
        .ctrl       (ctrl),
        .addr       (alu_result),
        .rs2_data   (rs2_data),
        .dmem_rdata (dmem_rdata),
        .dmem_req   (lsu_req),
        .load_data  (load_data)
    );

    always_comb begin
        case (ctrl.wb_sel)
            WB_ALU:  wb_data = alu_result;
            WB_MUL:  wb_data = mul_result;
            WB_MEM:  wb_data = load_data;
            default: wb_data = pc + word_t'(4);
        endcase
    end

    // no architectural writes while reset is held
    assign wb = '{we: ctrl.wb_we && !reset, rd: rd, data: wb_data};

    always_comb begin
        dmem_req    = lsu_req;
        dmem_req.we = lsu_req.we && !reset;
    end

    assert property (@(posedge clk) reset |=> (pc == RESET_PC))
        else $error("rv_core: pc not at reset address after reset");

    // straight-line code advances by one word per cycle
    assert property (@(posedge clk) disable iff (reset)
        !(ctrl.branch_always || ctrl.branch_instr) |=> (pc == $past(pc) + word_t'(4)))
        else $error("rv_core: sequential pc step broken");

endmodule

`default_nettype wire

/* hdl/rv_pkg.sv */
// shared widths, select encodings and control bundles, imported by every RTL module of the core
`default_nettype none

package rv_pkg;

    localparam int XLEN  = 32;
    localparam int NREGS = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [3:0]      be_t;

    // address the core starts from after reset
    localparam word_t RESET_PC = '0;

    // encoded as funct3 so the decoder can cast directly
    typedef enum logic [2:0] {
        ALU_ADD  = 3'b000,
        ALU_SLL  = 3'b001,
        ALU_SLT  = 3'b010,
        ALU_SLTU = 3'b011,
        ALU_XOR  = 3'b100,
        ALU_SRL  = 3'b101,
        ALU_OR   = 3'b110,
        ALU_AND  = 3'b111
    } alu_op_t;

    // low two bits of funct3 under the M extension, division left out
    typedef enum logic [1:0] {
        MUL_MUL    = 2'b00,
        MUL_MULH   = 2'b01,
        MUL_MULHSU = 2'b10,
        MUL_MULHU  = 2'b11
    } mul_op_t;

    // funct3 of the branch opcode, 010 and 011 are reserved
    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } branch_op_t;

    typedef enum logic [1:0] {A_ZERO, A_RS1, A_IMM} alu_a_sel_t;

    typedef enum logic [1:0] {B_RS2, B_IMM, B_PC} alu_b_sel_t;

    typedef enum logic [1:0] {WB_ALU, WB_MUL, WB_MEM, WB_PC_PLUS_4} wb_sel_t;

    // matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_width_t;

    typedef struct packed {
        alu_a_sel_t alu_a_sel;
        alu_b_sel_t alu_b_sel;
        alu_op_t    alu_op;
        logic       sub_arith;
        mul_op_t    mul_op;
        logic       branch_instr;
        logic       branch_always;
        branch_op_t branch_op;
        logic       dmem_we;
        logic       dmem_re;
        logic       dmem_sign_extend;
        mem_width_t dmem_width;
        wb_sel_t    wb_sel;
        logic       wb_we;
    } ctrl_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        be_t   be;
        logic  we;
    } dmem_req_t;

    typedef struct packed {
        logic     we;
        reg_idx_t rd;
        word_t    data;
    } wb_t;

endpackage

`default_nettype wire

/* rv_core.f */
hdl/rv_pkg.sv
hdl/decoder.sv
hdl/regfile.sv
hdl/alu.sv
hdl/branch_unit.sv
hdl/load_store_unit.sv
hdl/rv_core.sv
+incdir+sim
sim/rv_core_tb.sv

/* sim/rv_iss.svh */
// RV32IM reference model included by the testbench, steps one instruction per call
`ifndef RV_ISS_SVH
`define RV_ISS_SVH

logic [31:0] m_regs [32];
logic [31:0] m_pc;
logic [31:0] m_mem [256];

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic [31:0] x,
                                         input logic [31:0] y, input logic alt);
    case (f3)
        3'd0: return alt ? x - y : x + y;
        3'd1: return x << y[4:0];
        3'd2: return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
        3'd3: return (x < y) ? 32'd1 : 32'd0;
        3'd4: return x ^ y;
        3'd5: return alt ? 32'($signed(x) >>> y[4:0]) : x >> y[4:0];
        3'd6: return x | y;
        default: return x & y;
    endcase
endfunction

task automatic iss_step(input logic [31:0] ins, output logic we, output logic [4:0] rd,
                        output logic [31:0] val, output logic st, output logic [3:0] st_be,
                        output logic [31:0] st_addr, output logic [31:0] st_data);
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] immi;
    logic [31:0] imms;
    logic [31:0] immb;
    logic [31:0] immj;
    logic [31:0] addr;
    logic [31:0] w;
    logic [31:0] npc;
    logic [63:0] p;
    logic        taken;
    f3   = ins[14:12];
    rd   = ins[11:7];
    a    = m_regs[ins[19:15]];
    b    = m_regs[ins[24:20]];
    immi = {{20{ins[31]}}, ins[31:20]};
    imms = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    immb = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    immj = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    addr = (ins[6:0] == 7'h23) ? a + imms : a + immi;
    w    = m_mem[addr[9:2]] >> (8 * addr[1:0]);
    npc  = m_pc + 4;
    we   = 1'b1;
    val  = '0;
    st      = 1'b0;
    st_be   = '0;
    st_addr = addr;
    st_data = '0;
    case (ins[6:0])
        7'h37: val = {ins[31:12], 12'b0};
        7'h17: val = m_pc + {ins[31:12], 12'b0};
        7'h6f: begin
            val = m_pc + 4;
            npc = m_pc + immj;
        end
        7'h67: begin
            val = m_pc + 4;
            npc = (a + immi) & ~32'd1;
        end
        7'h63: begin
            we = 1'b0;
            case (f3)
                3'd0: taken = (a == b);
                3'd1: taken = (a != b);
                3'd4: taken = $signed(a) < $signed(b);
                3'd5: taken = $signed(a) >= $signed(b);
                3'd6: taken = a < b;
                default: taken = a >= b;
            endcase
            if (taken) npc = m_pc + immb;
        end
        7'h03: begin
            case (f3)
                3'd0: val = {{24{w[7]}}, w[7:0]};
                3'd1: val = {{16{w[15]}}, w[15:0]};
                3'd4: val = {24'b0, w[7:0]};
                3'd5: val = {16'b0, w[15:0]};
                default: val = m_mem[addr[9:2]];
            endcase
        end
        7'h23: begin
            we = 1'b0;
            st = 1'b1;
            // low bytes of rs2 moved up to the addressed lanes
            st_be   = (f3 == 3'd0) ? 4'b0001 : ((f3 == 3'd1) ? 4'b0011 : 4'b1111);
            st_be   = st_be << addr[1:0];
            st_data = b << (8 * addr[1:0]);
            for (int i = 0; i < 4; i++) begin
                if (st_be[i]) begin
                    m_mem[addr[9:2]][8*i +: 8] = st_data[8*i +: 8];
                end
            end
        end
        7'h13: val = alu_ref(f3, a, immi, (f3 == 3'd5) && ins[30]);
        7'h33: begin
            if (ins[31:25] == 7'd1) begin
                case (f3[1:0])
                    2'd0, 2'd1: p = {{32{a[31]}}, a} * {{32{b[31]}}, b};
                    2'd2: p = {{32{a[31]}}, a} * {32'b0, b};
                    default: p = {32'b0, a} * {32'b0, b};
                endcase
                val = (f3[1:0] == 2'd0) ? p[31:0] : p[63:32];
            end else begin
                val = alu_ref(f3, a, b, ins[30]);
            end
        end
        default: we = 1'b0;
    endcase
    if (we && rd != 0) m_regs[rd] = val;
    m_pc = npc;
endtask

`endif

/* sim/rv_core_tb.sv */
// testbench for the RV32IM core, runs encoded programs against the reference model in lockstep
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;
    import rv_pkg::*;

    logic      clk = 1'b0;
    logic      reset = 1'b1;
    word_t     imem_addr;
    word_t     imem_data;
    dmem_req_t dmem_req;
    word_t     dmem_rdata;
    wb_t       wb;

    word_t     imem [256];
    word_t     dmem [256];
    word_t     prog [$];
    int        errors = 0;
    int        failed_tests = 0;
    int        total_tests = 0;
    int        cycles = 0;
    int        limit = 100;

    `include "rv_iss.svh"

    rv_core i_rv_core (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .wb         (wb)
    );

    always #4 clk = ~clk;

    assign imem_data  = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_req.addr[9:2]];

    always @(posedge clk) begin
        if (dmem_req.we) begin
            for (int i = 0; i < 4; i++) begin
                if (dmem_req.be[i]) dmem[dmem_req.addr[9:2]][8*i +: 8] <= dmem_req.wdata[8*i +: 8];
            end
        end
    end

    // run limit grows as programs are loaded
    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: core did not finish its programs within %0d cycles", limit);
            $display("Verification failed");
            $finish;
        end
    end

    function automatic word_t fill_word(input int i);
        word_t a;
        a = word_t'(i * 4);
        return (a * 32'h9e37_79b1) ^ {a[15:0], ~a[15:0]};
    endfunction

    // byte enables widened to a bit mask
    function automatic word_t lane_mask(input be_t be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                    input logic [2:0] f3, input int rd, input logic [6:0] op);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input int rs1, input logic [2:0] f3,
                                    input int rd, input logic [6:0] op);
        return {imm, 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input int rs2, input int rs1,
                                    input logic [2:0] f3);
        return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], 7'h23};
    endfunction

    function automatic word_t enc_b(input logic [12:0] imm, input int rs2, input int rs1,
                                    input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic word_t enc_j(input logic [20:0] imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'h6f};
    endfunction

    // lui plus addi, upper part rounded for the sign of the low part
    task automatic load_const(input int rd, input word_t v);
        word_t hi;
        hi = v + 32'h800;
        prog.push_back({hi[31:12], 5'(rd), 7'h37});
        prog.push_back(enc_i(v[11:0], rd, 3'd0, rd, 7'h13));
    endtask

    task automatic run_test(input string name);
        int    errs;
        logic  exp_we;
        logic  [4:0] exp_rd;
        word_t exp_val;
        logic  exp_st;
        be_t   exp_be;
        word_t exp_addr;
        word_t exp_data;
        errs = errors;
        limit += prog.size() * 2;
        @(posedge clk);
        #1 reset = 1'b1;
        // memories reloaded while the core is held in reset
        for (int i = 0; i < 256; i++) begin
            imem[i]   = (i < prog.size()) ? prog[i] : 32'h0000_0013;
            dmem[i]   = fill_word(i);
            m_mem[i]  = fill_word(i);
        end
        for (int i = 0; i < 32; i++) m_regs[i] = '0;
        m_pc = RESET_PC;
        repeat (3) @(posedge clk);
        @(negedge clk);
        assert (!wb.we) else begin
            errors++;
            $display("%s: register write enabled while reset is high", name);
        end
        @(posedge clk);
        #1 reset = 1'b0;
        forever begin
            @(negedge clk);
            if (m_pc >= word_t'(prog.size() * 4)) break;
            assert (imem_addr == m_pc) else begin
                errors++;
                $display("mismatch %s pc: expected %h actual %h", name, m_pc, imem_addr);
            end
            iss_step(imem[m_pc[9:2]], exp_we, exp_rd, exp_val,
                     exp_st, exp_be, exp_addr, exp_data);
            assert (wb.we == exp_we && (!exp_we || (wb.rd == exp_rd && wb.data == exp_val)))
            else begin
                errors++;
                $display("mismatch %s at pc %h: expected we %b x%0d=%h actual we %b x%0d=%h",
                         name, imem_addr, exp_we, exp_rd, exp_val, wb.we, wb.rd, wb.data);
            end
            assert (dmem_req.we == exp_st && (!exp_st || (dmem_req.addr == exp_addr &&
                    dmem_req.be == exp_be &&
                    (dmem_req.wdata & lane_mask(exp_be)) == (exp_data & lane_mask(exp_be)))))
            else begin
                errors++;
                $display({"mismatch %s store at pc %h: expected we %b addr %h be %b data %h",
                          " actual we %b addr %h be %b data %h"},
                         name, imem_addr, exp_st, exp_addr, exp_be,
                         exp_data & lane_mask(exp_be), dmem_req.we, dmem_req.addr,
                         dmem_req.be, dmem_req.wdata & lane_mask(dmem_req.be));
            end
        end
        total_tests++;
        if (errors != errs) failed_tests++;
        $display("test %s: %0d errors", name, errors - errs);
        prog.delete();
    endtask

    initial begin
        word_t       ops [4];
        int          k;
        int          n;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        void'($urandom(32'h4ceb_e61b));

        // integer ALU
        load_const(1, 32'hf000_0f07);
        load_const(2, 32'h0000_0013);
        load_const(3, 32'h8000_0005);
        for (int f = 0; f < 8; f++) begin
            prog.push_back(enc_r(7'h00, 2, 1, 3'(f), 10 + f, 7'h33));
            prog.push_back(enc_r(7'h00, 1, 3, 3'(f), 18 + f, 7'h33));
            prog.push_back(enc_i((f == 1 || f == 5) ? 12'd7 : 12'hf85, 1, 3'(f), 26, 7'h13));
        end
        prog.push_back(enc_r(7'h20, 2, 1, 3'd0, 4, 7'h33));
        prog.push_back(enc_r(7'h20, 2, 1, 3'd5, 5, 7'h33));
        prog.push_back(enc_i(12'h409, 3, 3'd5, 6, 7'h13));
        prog.push_back({20'habcde, 5'd7, 7'h37});
        prog.push_back({20'h12345, 5'd8, 7'h17});
        run_test("alu");

        // branches, taken and not taken, each skipping one addi
        load_const(1, 32'hffff_ffff);
        load_const(2, 32'h0000_0001);
        for (int f = 0; f < 8; f++) begin
            if (f == 2 || f == 3) continue;
            prog.push_back(enc_b(13'd8, 2, 1, 3'(f)));
            prog.push_back(enc_i(12'd1, 5, 3'd0, 5, 7'h13));
            prog.push_back(enc_b(13'd8, 1, 1, 3'(f)));
            prog.push_back(enc_i(12'd1, 5, 3'd0, 5, 7'h13));
            prog.push_back(enc_b(13'd8, 1, 2, 3'(f)));
            prog.push_back(enc_i(12'd1, 5, 3'd0, 5, 7'h13));
        end
        prog.push_back(enc_j(21'd8, 6));
        prog.push_back(enc_i(12'd1, 5, 3'd0, 5, 7'h13));
        prog.push_back(enc_i(12'(prog.size() * 4 + 9), 0, 3'd0, 7, 7'h67));
        prog.push_back(enc_i(12'd1, 5, 3'd0, 5, 7'h13));
        prog.push_back(enc_i(12'd1, 5, 3'd0, 5, 7'h13));
        run_test("branch");

        // stores at every legal offset, then every load form
        load_const(1, 32'h8a7b_6c5d);
        for (int o = 0; o < 4; o++) begin
            prog.push_back(enc_s(12'(16 + o), 1, 0, 3'd0));
            prog.push_back(enc_i(12'h1b5, 1, 3'd0, 1, 7'h13));
        end
        for (int o = 0; o < 4; o += 2) begin
            prog.push_back(enc_s(12'(32 + o), 1, 0, 3'd1));
            prog.push_back(enc_i(12'h1b5, 1, 3'd0, 1, 7'h13));
        end
        prog.push_back(enc_s(12'd48, 1, 0, 3'd2));
        for (int o = 0; o < 4; o++) begin
            prog.push_back(enc_i(12'(16 + o), 0, 3'd0, 2, 7'h03));
            prog.push_back(enc_i(12'(16 + o), 0, 3'd4, 3, 7'h03));
        end
        for (int o = 0; o < 4; o += 2) begin
            prog.push_back(enc_i(12'(32 + o), 0, 3'd1, 4, 7'h03));
            prog.push_back(enc_i(12'(32 + o), 0, 3'd5, 5, 7'h03));
        end
        prog.push_back(enc_i(12'd48, 0, 3'd2, 6, 7'h03));
        prog.push_back(enc_i(12'd52, 0, 3'd2, 7, 7'h03));
        run_test("load_store");

        // multiply corners
        ops[0] = 32'h0;
        ops[1] = 32'hffff_ffff;
        ops[2] = 32'h8000_0000;
        ops[3] = $urandom;
        foreach (ops[i]) load_const(1 + i, ops[i]);
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                for (int f = 0; f < 4; f++) begin
                    prog.push_back(enc_r(7'h01, 1 + j, 1 + i, 3'(f), 5 + f, 7'h33));
                end
            end
        end
        run_test("mul");

        // x0 stays zero
        prog.push_back(enc_i(12'd5, 0, 3'd0, 0, 7'h13));
        prog.push_back(enc_r(7'h00, 0, 0, 3'd0, 1, 7'h33));
        prog.push_back({20'hfffff, 5'd0, 7'h37});
        prog.push_back(enc_r(7'h00, 0, 0, 3'd0, 2, 7'h33));
        run_test("reset_x0");

        // random legal program, forward control flow only
        n = 200;
        while (prog.size() < n) begin
            k = prog.size();
            case ($urandom % 9)
                0: begin
                    f3 = 3'($urandom);
                    f7 = ((f3 == 3'd0 || f3 == 3'd5) && ($urandom % 2)) ? 7'h20 : 7'h00;
                    prog.push_back(enc_r(f7, $urandom % 32, $urandom % 32, f3,
                                         $urandom % 32, 7'h33));
                end
                1: begin
                    f3  = 3'($urandom);
                    imm = 12'($urandom);
                    // shift immediates hold only shamt and the arithmetic flag
                    if (f3 == 3'd1) imm = imm & 12'h01f;
                    if (f3 == 3'd5) imm = imm & 12'h41f;
                    prog.push_back(enc_i(imm, $urandom % 32, f3, $urandom % 32, 7'h13));
                end
                2: prog.push_back(enc_r(7'h01, $urandom % 32, $urandom % 32,
                                        3'($urandom % 4), $urandom % 32, 7'h33));
                3: prog.push_back({20'($urandom), 5'($urandom), ($urandom % 2) ? 7'h37 : 7'h17});
                4: prog.push_back(enc_i(12'(($urandom % 256) * 4), 0,
                                        3'd2, $urandom % 32, 7'h03));
                5: prog.push_back(enc_s(12'(($urandom % 512) * 2), $urandom % 32, 0,
                                        3'($urandom % 2)));
                6: prog.push_back(enc_b(13'(4 * (1 + $urandom % ((n - k) < 4 ? n - k : 4))),
                                        $urandom % 32, $urandom % 32,
                                        ($urandom % 2) ? 3'd4 | 3'($urandom % 4) : 3'($urandom % 2)));
                7: prog.push_back(enc_j(21'(4 * (1 + $urandom % ((n - k) < 3 ? n - k : 3))),
                                        $urandom % 32));
                default: prog.push_back(enc_i(12'(k * 4 + 8), 0, 3'd0, $urandom % 32, 7'h67));
            endcase
        end
        run_test("random");

        $display("tests %0d, failed %0d, errors %0d", total_tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
